/* logic/cache_geom_pkg.sv */
// Fixed geometry of 16 sets x 4 ways x 4 words; changing it means rebuilding every block
package cache_geom_pkg;

    localparam int unsigned N_SETS     = 16;
    localparam int unsigned N_WAYS     = 4;
    localparam int unsigned LINE_WORDS = 4;
    localparam int unsigned WORD_BITS  = 32;
    localparam int unsigned TAG_BITS   = 8;

    typedef logic [$clog2(N_SETS)-1:0]     set_t;
    typedef logic [TAG_BITS-1:0]           tag_t;
    typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t;
    typedef logic [N_WAYS-1:0]             way_vec_t;
    typedef logic [WORD_BITS-1:0]          word_t;
    typedef logic [WORD_BITS/8-1:0]        be_t;

    // Flat index into a per-way data RAM, set in the upper bits
    typedef logic [$clog2(N_SETS*LINE_WORDS)-1:0] data_addr_t;

    // One directory entry; valid bits live in flops, not in the RAM
    typedef struct packed {
        tag_t tag;
    } dir_entry_t;

endpackage

/* logic/cache_op_pkg.sv */
// Operation selects only; encodings are internal and never leave the design
package cache_op_pkg;

    typedef enum logic {
        INIT_SWEEP,
        INIT_DONE
    } init_state_e;

    typedef enum logic [1:0] {
        DIR_IDLE,
        DIR_INIT,
        DIR_MATCH,
        DIR_REFILL
    } dir_op_e;

    typedef enum logic [1:0] {
        DATA_IDLE,
        DATA_READ,
        DATA_WRITE,
        DATA_REFILL
    } data_op_e;

endpackage

/* logic/dir_ram_if.sv */
// Directory RAM port; wentry is shared by all ways, rentry is valid one cycle after a read
`timescale 1ns/1ps

interface dir_ram_if;
    import cache_geom_pkg::*;

    set_t                    addr;
    way_vec_t                cs;
    way_vec_t                we;
    dir_entry_t              wentry;
    dir_entry_t [N_WAYS-1:0] rentry;

    modport ctrl (
        output addr, cs, we, wentry,
        input  rentry
    );

    modport ram (
        input  addr, cs, we, wentry,
        output rentry
    );

endinterface

/* logic/dir_init.sv */
// Runs exactly once per reset; ready_o rises N_SETS cycles after rst_ni is released
`timescale 1ns/1ps

module dir_init (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    output logic                 busy_o,
    output cache_geom_pkg::set_t sweep_set_o,
    output logic                 ready_o
);
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    init_state_e state_q;
    set_t        set_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= INIT_SWEEP;
            set_q   <= '0;
        end else if (state_q == INIT_SWEEP) begin
            set_q <= set_q + 1'b1;
            // Last set written on this edge
            if (set_q == set_t'(N_SETS - 1)) begin
                state_q <= INIT_DONE;
            end
        end
    end

    assign busy_o      = (state_q == INIT_SWEEP);
    assign ready_o     = (state_q == INIT_DONE);
    assign sweep_set_o = set_q;

endmodule

/* logic/dir_ctrl.sv */
// Invalidate only touches valid flops, so it never occupies the tag RAM port
`timescale 1ns/1ps

module dir_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     match_i,
    input  cache_geom_pkg::set_t     match_set_i,
    input  cache_geom_pkg::tag_t     match_tag_i,
    input  logic                     refill_i,
    input  cache_geom_pkg::set_t     refill_set_i,
    input  cache_geom_pkg::tag_t     refill_tag_i,
    input  logic                     inval_i,
    input  cache_geom_pkg::set_t     inval_set_i,
    input  cache_geom_pkg::way_vec_t inval_way_i,
    input  logic                     init_busy_i,
    input  cache_geom_pkg::set_t     init_set_i,
    input  cache_geom_pkg::way_vec_t victim_way_i,
    output cache_geom_pkg::set_t     lookup_set_o,
    output cache_geom_pkg::way_vec_t hit_way_o,
    output cache_geom_pkg::way_vec_t refill_valid_o,
    dir_ram_if.ctrl                  dir_ram
);
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    dir_op_e              op;
    way_vec_t [N_SETS-1:0] valid_q;
    logic                 match_q;
    set_t                 lookup_set_q;
    tag_t                 lookup_tag_q;

    // Init wins, then match, then refill
    always_comb begin
        if (init_busy_i) begin
            op = DIR_INIT;
        end else if (match_i) begin
            op = DIR_MATCH;
        end else if (refill_i) begin
            op = DIR_REFILL;
        end else begin
            op = DIR_IDLE;
        end
    end

    always_comb begin
        dir_ram.addr   = '0;
        dir_ram.cs     = '0;
        dir_ram.we     = '0;
        dir_ram.wentry = '0;
        case (op)
            DIR_INIT: begin
                dir_ram.addr = init_set_i;
                dir_ram.cs   = '1;
                dir_ram.we   = '1;
            end
            DIR_MATCH: begin
                dir_ram.addr = match_set_i;
                dir_ram.cs   = '1;
            end
            DIR_REFILL: begin
                dir_ram.addr       = refill_set_i;
                dir_ram.cs         = victim_way_i;
                dir_ram.we         = victim_way_i;
                dir_ram.wentry.tag = refill_tag_i;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            match_q <= 1'b0;
        end else begin
            match_q <= match_i;
            if (refill_i) begin
                valid_q[refill_set_i] <= valid_q[refill_set_i] | victim_way_i;
            end else if (inval_i) begin
                valid_q[inval_set_i] <= valid_q[inval_set_i] & ~inval_way_i;
            end
        end
    end

    // Lookup key kept for the compare in the next cycle
    always_ff @(posedge clk_i) begin
        if (match_i) begin
            lookup_set_q <= match_set_i;
            lookup_tag_q <= match_tag_i;
        end
    end

    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            hit_way_o[w] = match_q && valid_q[lookup_set_q][w] &&
                           (dir_ram.rentry[w].tag == lookup_tag_q);
        end
    end

    assign lookup_set_o   = lookup_set_q;
    assign refill_valid_o = valid_q[refill_set_i];

    dir_strobe_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({match_i, refill_i, inval_i}))
        else $error("dir_ctrl: more than one directory strobe");

    // The sweep owns the RAM port until it finishes
    dir_req_while_init_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (match_i || refill_i || inval_i) |-> !init_busy_i)
        else $error("dir_ctrl: directory request during init sweep");

endmodule

/* logic/plru_repl.sv */
// Victim is combinational from the current state; marks from hits and refills land at the edge
`timescale 1ns/1ps

module plru_repl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     updt_i,
    input  cache_geom_pkg::set_t     updt_set_i,
    input  cache_geom_pkg::way_vec_t updt_way_i,
    input  logic                     repl_i,
    input  cache_geom_pkg::set_t     repl_set_i,
    input  cache_geom_pkg::way_vec_t repl_valid_i,
    output cache_geom_pkg::way_vec_t victim_way_o
);
    import cache_geom_pkg::*;

    way_vec_t [N_SETS-1:0] plru_q;
    way_vec_t [N_SETS-1:0] plru_d;

    // Set the way's bit, restart from it when the set would saturate
    function automatic way_vec_t plru_mark(way_vec_t bits, way_vec_t way);
        way_vec_t nxt;
        nxt = bits | way;
        if (&nxt) begin
            nxt = way;
        end
        return nxt;
    endfunction

    function automatic way_vec_t lowest_zero(way_vec_t bits);
        way_vec_t sel;
        sel = '0;
        for (int i = N_WAYS - 1; i >= 0; i--) begin
            if (!bits[i]) begin
                sel = way_vec_t'(1) << i;
            end
        end
        return sel;
    endfunction

    // Invalid ways first
    assign victim_way_o = (&repl_valid_i) ? lowest_zero(plru_q[repl_set_i])
                                          : lowest_zero(repl_valid_i);

    always_comb begin
        plru_d = plru_q;
        if (updt_i) begin
            plru_d[updt_set_i] = plru_mark(plru_d[updt_set_i], updt_way_i);
        end
        if (repl_i) begin
            plru_d[repl_set_i] = plru_mark(plru_d[repl_set_i], victim_way_o);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            plru_q <= '0;
        end else begin
            plru_q <= plru_d;
        end
    end

    victim_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        repl_i |-> $onehot(victim_way_o))
        else $error("plru_repl: victim is not one-hot");

endmodule

/* logic/data_ctrl.sv */
// Read data is only meaningful the cycle after a read that was issued together with a match
`timescale 1ns/1ps

module data_ctrl (
    input  logic                                            clk_i,
    input  logic                                            read_i,
    input  cache_geom_pkg::set_t                            read_set_i,
    input  cache_geom_pkg::word_idx_t                       read_word_i,
    input  logic                                            write_i,
    input  cache_geom_pkg::set_t                            write_set_i,
    input  cache_geom_pkg::word_idx_t                       write_word_i,
    input  cache_geom_pkg::word_t                           write_data_i,
    input  cache_geom_pkg::be_t                             write_be_i,
    input  logic                                            refill_i,
    input  cache_geom_pkg::way_vec_t                        refill_way_i,
    input  cache_geom_pkg::set_t                            refill_set_i,
    input  cache_geom_pkg::word_idx_t                       refill_word_i,
    input  cache_geom_pkg::word_t                           refill_data_i,
    input  cache_geom_pkg::way_vec_t                        hit_way_i,
    output cache_geom_pkg::set_t                            ram_addr_o,
    output cache_geom_pkg::word_idx_t                       ram_word_o,
    output cache_geom_pkg::way_vec_t                        ram_we_o,
    output cache_geom_pkg::be_t                             ram_be_o,
    output cache_geom_pkg::word_t                           ram_wdata_o,
    input  cache_geom_pkg::word_t [cache_geom_pkg::N_WAYS-1:0] ram_rdata_i,
    output cache_geom_pkg::word_t                           read_data_o
);
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    data_op_e op;
    logic     read_q;

    assign op = refill_i ? DATA_REFILL :
                write_i  ? DATA_WRITE  :
                read_i   ? DATA_READ   : DATA_IDLE;

    always_comb begin
        ram_addr_o  = '0;
        ram_word_o  = '0;
        ram_we_o    = '0;
        ram_be_o    = '0;
        ram_wdata_o = '0;
        case (op)
            DATA_REFILL: begin
                ram_addr_o  = refill_set_i;
                ram_word_o  = refill_word_i;
                ram_we_o    = refill_way_i;
                ram_be_o    = '1;
                ram_wdata_o = refill_data_i;
            end
            // Store goes to whichever way the directory reports this cycle
            DATA_WRITE: begin
                ram_addr_o  = write_set_i;
                ram_word_o  = write_word_i;
                ram_we_o    = hit_way_i;
                ram_be_o    = write_be_i;
                ram_wdata_o = write_data_i;
            end
            DATA_READ: begin
                ram_addr_o = read_set_i;
                ram_word_o = read_word_i;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        read_q <= read_i;
    end

    // One-hot hit select, a miss gives zero
    always_comb begin
        read_data_o = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (read_q && hit_way_i[w]) begin
                read_data_o = read_data_o | ram_rdata_i[w];
            end
        end
    end

    data_strobe_onehot_a: assert property (@(posedge clk_i)
        $onehot0({read_i, write_i, refill_i}))
        else $error("data_ctrl: more than one data strobe");

endmodule

/* logic/cache_arrays.sv */
// Behavioral RAMs with contents undefined until written; read-during-write returns old data
`timescale 1ns/1ps

module cache_arrays (
    input  logic                                               clk_i,
    dir_ram_if.ram                                             dir_ram,
    input  cache_geom_pkg::set_t                               data_addr_i,
    input  cache_geom_pkg::word_idx_t                          data_word_i,
    input  cache_geom_pkg::way_vec_t                           data_we_i,
    input  cache_geom_pkg::be_t                                data_be_i,
    input  cache_geom_pkg::word_t                              data_wdata_i,
    output cache_geom_pkg::word_t [cache_geom_pkg::N_WAYS-1:0] data_rdata_o
);
    import cache_geom_pkg::*;

    dir_entry_t tag_mem  [N_WAYS][N_SETS];
    word_t      data_mem [N_WAYS][N_SETS*LINE_WORDS];
    data_addr_t data_idx;

    assign data_idx = {data_addr_i, data_word_i};

    for (genvar w = 0; w < N_WAYS; w++) begin : g_way
        // Tag RAM reads only when selected without write
        always_ff @(posedge clk_i) begin
            if (dir_ram.cs[w]) begin
                if (dir_ram.we[w]) begin
                    tag_mem[w][dir_ram.addr] <= dir_ram.wentry;
                end else begin
                    dir_ram.rentry[w] <= tag_mem[w][dir_ram.addr];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            data_rdata_o[w] <= data_mem[w][data_idx];
            for (int b = 0; b < WORD_BITS/8; b++) begin
                if (data_we_i[w] && data_be_i[b]) begin
                    data_mem[w][data_idx][8*b +: 8] <= data_wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

/* logic/cache_memctrl.sv */
// Strobes have no handshake: one directory and one data strobe per cycle at most, none before ready_o
`timescale 1ns/1ps

module cache_memctrl (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    output logic                      ready_o,

    input  logic                      dir_match_i,
    input  cache_geom_pkg::set_t      dir_match_set_i,
    input  cache_geom_pkg::tag_t      dir_match_tag_i,
    output cache_geom_pkg::way_vec_t  dir_hit_way_o,

    input  logic                      dir_refill_i,
    input  cache_geom_pkg::set_t      dir_refill_set_i,
    input  cache_geom_pkg::tag_t      dir_refill_tag_i,
    output cache_geom_pkg::way_vec_t  dir_victim_way_o,

    input  logic                      dir_inval_i,
    input  cache_geom_pkg::set_t      dir_inval_set_i,
    input  cache_geom_pkg::way_vec_t  dir_inval_way_i,

    input  logic                      data_read_i,
    input  cache_geom_pkg::set_t      data_read_set_i,
    input  cache_geom_pkg::word_idx_t data_read_word_i,
    output cache_geom_pkg::word_t     data_read_data_o,

    input  logic                      data_write_i,
    input  cache_geom_pkg::set_t      data_write_set_i,
    input  cache_geom_pkg::word_idx_t data_write_word_i,
    input  cache_geom_pkg::word_t     data_write_data_i,
    input  cache_geom_pkg::be_t       data_write_be_i,

    input  logic                      data_refill_i,
    input  cache_geom_pkg::way_vec_t  data_refill_way_i,
    input  cache_geom_pkg::set_t      data_refill_set_i,
    input  cache_geom_pkg::word_idx_t data_refill_word_i,
    input  cache_geom_pkg::word_t     data_refill_data_i
);
    import cache_geom_pkg::*;

    logic               init_busy;
    set_t               init_set;
    set_t               lookup_set;
    way_vec_t           refill_valid;

    set_t               ram_addr;
    word_idx_t          ram_word;
    way_vec_t           ram_we;
    be_t                ram_be;
    word_t              ram_wdata;
    word_t [N_WAYS-1:0] ram_rdata;

    dir_ram_if dir_ram ();

    dir_init dir_init_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .busy_o      (init_busy),
        .sweep_set_o (init_set),
        .ready_o     (ready_o)
    );

    dir_ctrl dir_ctrl_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .match_i        (dir_match_i),
        .match_set_i    (dir_match_set_i),
        .match_tag_i    (dir_match_tag_i),
        .refill_i       (dir_refill_i),
        .refill_set_i   (dir_refill_set_i),
        .refill_tag_i   (dir_refill_tag_i),
        .inval_i        (dir_inval_i),
        .inval_set_i    (dir_inval_set_i),
        .inval_way_i    (dir_inval_way_i),
        .init_busy_i    (init_busy),
        .init_set_i     (init_set),
        .victim_way_i   (dir_victim_way_o),
        .lookup_set_o   (lookup_set),
        .hit_way_o      (dir_hit_way_o),
        .refill_valid_o (refill_valid),
        .dir_ram        (dir_ram.ctrl)
    );

    plru_repl plru_repl_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .updt_i       (|dir_hit_way_o),
        .updt_set_i   (lookup_set),
        .updt_way_i   (dir_hit_way_o),
        .repl_i       (dir_refill_i),
        .repl_set_i   (dir_refill_set_i),
        .repl_valid_i (refill_valid),
        .victim_way_o (dir_victim_way_o)
    );

    data_ctrl data_ctrl_inst (
        .clk_i         (clk_i),
        .read_i        (data_read_i),
        .read_set_i    (data_read_set_i),
        .read_word_i   (data_read_word_i),
        .write_i       (data_write_i),
        .write_set_i   (data_write_set_i),
        .write_word_i  (data_write_word_i),
        .write_data_i  (data_write_data_i),
        .write_be_i    (data_write_be_i),
        .refill_i      (data_refill_i),
        .refill_way_i  (data_refill_way_i),
        .refill_set_i  (data_refill_set_i),
        .refill_word_i (data_refill_word_i),
        .refill_data_i (data_refill_data_i),
        .hit_way_i     (dir_hit_way_o),
        .ram_addr_o    (ram_addr),
        .ram_word_o    (ram_word),
        .ram_we_o      (ram_we),
        .ram_be_o      (ram_be),
        .ram_wdata_o   (ram_wdata),
        .ram_rdata_i   (ram_rdata),
        .read_data_o   (data_read_data_o)
    );

    cache_arrays cache_arrays_inst (
        .clk_i        (clk_i),
        .dir_ram      (dir_ram.ram),
        .data_addr_i  (ram_addr),
        .data_word_i  (ram_word),
        .data_we_i    (ram_we),
        .data_be_i    (ram_be),
        .data_wdata_i (ram_wdata),
        .data_rdata_o (ram_rdata)
    );

endmodule

/* sim/tb_clk_gen.sv */
// Clock starts low at time zero; reset is released on the falling edge after three rising edges
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);
    localparam int HALF_PERIOD = 2;
    localparam int RST_CYCLES  = 3;

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        // Away from the rising edge so the release is clean
        @(negedge clk_o);
        rst_no = 1'b1;
    end

    always #HALF_PERIOD clk_o = ~clk_o;

endmodule

/* sim/tb_cache_memctrl.sv */
// Directed checks that all work on one set; expected values come from a tag, valid and PLRU model
`timescale 1ns/1ps

module tb_cache_memctrl;
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    localparam int   SEED           = 86;
    // The whole run needs a few hundred cycles
    localparam int   TIMEOUT_CYCLES = 2000;
    localparam set_t TEST_SET       = 4'd5;

    logic      clk_i;
    logic      rst_ni;
    logic      ready_o;
    logic      dir_match_i;
    set_t      dir_match_set_i;
    tag_t      dir_match_tag_i;
    way_vec_t  dir_hit_way_o;
    logic      dir_refill_i;
    set_t      dir_refill_set_i;
    tag_t      dir_refill_tag_i;
    way_vec_t  dir_victim_way_o;
    logic      dir_inval_i;
    set_t      dir_inval_set_i;
    way_vec_t  dir_inval_way_i;
    logic      data_read_i;
    set_t      data_read_set_i;
    word_idx_t data_read_word_i;
    word_t     data_read_data_o;
    logic      data_write_i;
    set_t      data_write_set_i;
    word_idx_t data_write_word_i;
    word_t     data_write_data_i;
    be_t       data_write_be_i;
    logic      data_refill_i;
    way_vec_t  data_refill_way_i;
    set_t      data_refill_set_i;
    word_idx_t data_refill_word_i;
    word_t     data_refill_data_i;

    // Model of the test set
    way_vec_t  valid_bits;
    way_vec_t  plru_bits;
    tag_t      tag_model [N_WAYS];
    word_t     line_model [N_WAYS][LINE_WORDS];
    int        cycle_cnt = 0;

    tb_clk_gen tb_clk_gen_inst (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    cache_memctrl cache_memctrl_inst (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .ready_o            (ready_o),
        .dir_match_i        (dir_match_i),
        .dir_match_set_i    (dir_match_set_i),
        .dir_match_tag_i    (dir_match_tag_i),
        .dir_hit_way_o      (dir_hit_way_o),
        .dir_refill_i       (dir_refill_i),
        .dir_refill_set_i   (dir_refill_set_i),
        .dir_refill_tag_i   (dir_refill_tag_i),
        .dir_victim_way_o   (dir_victim_way_o),
        .dir_inval_i        (dir_inval_i),
        .dir_inval_set_i    (dir_inval_set_i),
        .dir_inval_way_i    (dir_inval_way_i),
        .data_read_i        (data_read_i),
        .data_read_set_i    (data_read_set_i),
        .data_read_word_i   (data_read_word_i),
        .data_read_data_o   (data_read_data_o),
        .data_write_i       (data_write_i),
        .data_write_set_i   (data_write_set_i),
        .data_write_word_i  (data_write_word_i),
        .data_write_data_i  (data_write_data_i),
        .data_write_be_i    (data_write_be_i),
        .data_refill_i      (data_refill_i),
        .data_refill_way_i  (data_refill_way_i),
        .data_refill_set_i  (data_refill_set_i),
        .data_refill_word_i (data_refill_word_i),
        .data_refill_data_i (data_refill_data_i)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_way(input string name, input way_vec_t got, input way_vec_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: tests still running after %0d cycles", cycle_cnt));
        end
    end

    task automatic mark_way(input int w);
        plru_bits[w] = 1'b1;
        // A saturated set restarts from the newest way
        if (&plru_bits) begin
            plru_bits    = '0;
            plru_bits[w] = 1'b1;
        end
    endtask

    function automatic int expected_victim();
        int v;
        v = -1;
        for (int w = 0; w < N_WAYS; w++) begin
            if (v < 0 && !valid_bits[w]) begin
                v = w;
            end
        end
        for (int w = 0; w < N_WAYS; w++) begin
            if (v < 0 && !plru_bits[w]) begin
                v = w;
            end
        end
        return v;
    endfunction

    // Match and read together, hit and data checked in the next cycle
    task automatic lookup(input tag_t tag, input word_idx_t widx);
        way_vec_t exp_hit;
        word_t    exp_data;
        int       hit_idx;
        exp_hit  = '0;
        exp_data = '0;
        hit_idx  = -1;
        for (int w = 0; w < N_WAYS; w++) begin
            if (valid_bits[w] && tag_model[w] == tag) begin
                exp_hit[w] = 1'b1;
                exp_data   = line_model[w][widx];
                hit_idx    = w;
            end
        end
        @(posedge clk_i);
        dir_match_i      <= 1'b1;
        dir_match_set_i  <= TEST_SET;
        dir_match_tag_i  <= tag;
        data_read_i      <= 1'b1;
        data_read_set_i  <= TEST_SET;
        data_read_word_i <= widx;
        @(posedge clk_i);
        dir_match_i <= 1'b0;
        data_read_i <= 1'b0;
        @(negedge clk_i);
        check_way("dir_hit_way_o", dir_hit_way_o, exp_hit);
        check_word("data_read_data_o", data_read_data_o, exp_data);
        if (hit_idx >= 0) begin
            mark_way(hit_idx);
        end
    endtask

    // Tag low bits carry the way index, which keeps tags in the set distinct
    task automatic refill_line();
        int   v;
        tag_t tag;
        v   = expected_victim();
        tag = {6'($urandom), 2'(v)};
        @(posedge clk_i);
        dir_refill_i     <= 1'b1;
        dir_refill_set_i <= TEST_SET;
        dir_refill_tag_i <= tag;
        @(negedge clk_i);
        check_way("dir_victim_way_o", dir_victim_way_o, way_vec_t'(1) << v);
        @(posedge clk_i);
        dir_refill_i <= 1'b0;
        mark_way(v);
        valid_bits[v] = 1'b1;
        tag_model[v]  = tag;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line_model[v][i] = $urandom;
            data_refill_i      <= 1'b1;
            data_refill_way_i  <= way_vec_t'(1) << v;
            data_refill_set_i  <= TEST_SET;
            data_refill_word_i <= word_idx_t'(i);
            data_refill_data_i <= line_model[v][i];
            @(posedge clk_i);
        end
        data_refill_i <= 1'b0;
    endtask

    task automatic write_after_hit(input int w, input word_idx_t widx, input word_t wdata,
                                   input be_t be);
        word_t merged;
        merged = line_model[w][widx];
        for (int b = 0; b < WORD_BITS / 8; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        @(posedge clk_i);
        dir_match_i     <= 1'b1;
        dir_match_set_i <= TEST_SET;
        dir_match_tag_i <= tag_model[w];
        @(posedge clk_i);
        dir_match_i       <= 1'b0;
        data_write_i      <= 1'b1;
        data_write_set_i  <= TEST_SET;
        data_write_word_i <= widx;
        data_write_data_i <= wdata;
        data_write_be_i   <= be;
        @(negedge clk_i);
        check_way("dir_hit_way_o", dir_hit_way_o, way_vec_t'(1) << w);
        @(posedge clk_i);
        data_write_i <= 1'b0;
        line_model[w][widx] = merged;
        mark_way(w);
    endtask

    task automatic invalidate_ways(input way_vec_t ways);
        @(posedge clk_i);
        dir_inval_i     <= 1'b1;
        dir_inval_set_i <= TEST_SET;
        dir_inval_way_i <= ways;
        @(posedge clk_i);
        dir_inval_i <= 1'b0;
        valid_bits = valid_bits & ~ways;
    endtask

    task automatic test_ready_timing();
        int cycles;
        cycles = 0;
        @(posedge rst_ni);
        check_bit("ready_o", ready_o, 1'b0);
        check_way("dir_hit_way_o", dir_hit_way_o, '0);
        while (!ready_o) begin
            @(negedge clk_i);
            cycles++;
        end
        if (cycles != N_SETS) begin
            abort_run($sformatf("ready_o rose %0d cycles after reset instead of %0d",
                                cycles, N_SETS));
        end
    endtask

    task automatic test_empty_miss();
        lookup(8'($urandom), 2'd0);
        // Init left zero tags behind, still no hit without valid bits
        lookup(8'h00, 2'd3);
    endtask

    task automatic test_fill_set();
        repeat (N_WAYS) refill_line();
        for (int w = 0; w < N_WAYS; w++) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                lookup(tag_model[w], word_idx_t'(i));
            end
        end
    endtask

    task automatic test_masked_write();
        write_after_hit(2, 2'd1, $urandom, 4'b0101);
        lookup(tag_model[2], 2'd1);
        lookup(tag_model[2], 2'd0);
    endtask

    task automatic test_plru_victims();
        repeat (6) begin
            lookup(tag_model[int'($urandom % N_WAYS)], word_idx_t'($urandom));
            lookup(tag_model[int'($urandom % N_WAYS)], word_idx_t'($urandom));
            refill_line();
        end
        for (int w = 0; w < N_WAYS; w++) begin
            lookup(tag_model[w], word_idx_t'($urandom));
        end
    endtask

    task automatic test_invalidate();
        tag_t old_tag;
        old_tag = tag_model[1];
        lookup(old_tag, 2'd0);
        invalidate_ways(4'b0010);
        lookup(old_tag, 2'd0);
        refill_line();
        lookup(tag_model[1], 2'd3);
    endtask

    initial begin
        void'($urandom(SEED));
        valid_bits = '0;
        plru_bits  = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            tag_model[w] = '0;
            for (int i = 0; i < LINE_WORDS; i++) begin
                line_model[w][i] = '0;
            end
        end
        dir_match_i        <= 1'b0;
        dir_match_set_i    <= '0;
        dir_match_tag_i    <= '0;
        dir_refill_i       <= 1'b0;
        dir_refill_set_i   <= '0;
        dir_refill_tag_i   <= '0;
        dir_inval_i        <= 1'b0;
        dir_inval_set_i    <= '0;
        dir_inval_way_i    <= '0;
        data_read_i        <= 1'b0;
        data_read_set_i    <= '0;
        data_read_word_i   <= '0;
        data_write_i       <= 1'b0;
        data_write_set_i   <= '0;
        data_write_word_i  <= '0;
        data_write_data_i  <= '0;
        data_write_be_i    <= '0;
        data_refill_i      <= 1'b0;
        data_refill_way_i  <= '0;
        data_refill_set_i  <= '0;
        data_refill_word_i <= '0;
        data_refill_data_i <= '0;

        test_ready_timing();
        test_empty_miss();
        test_fill_set();
        test_masked_write();
        test_plru_victims();
        test_invalidate();

        @(posedge clk_i);
        $display("No errors");
        $finish;
    end

endmodule

/* cache_memctrl.f */
logic/cache_geom_pkg.sv
logic/cache_op_pkg.sv
logic/dir_ram_if.sv
logic/dir_init.sv
logic/dir_ctrl.sv
logic/plru_repl.sv
logic/data_ctrl.sv
logic/cache_arrays.sv
logic/cache_memctrl.sv
sim/tb_clk_gen.sv
sim/tb_cache_memctrl.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_memctrl \
    -f cache_memctrl.f \
    && { ./obj_dir/Vtb_cache_memctrl > sim.log 2>&1 || true; } \
    && grep -q "No errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
